//--- common/uart_pkg.sv
`default_nettype none

package uart_pkg;

    localparam int CLK_FREQ = 10000000;
    localparam int BAUD = 125000;
    localparam int OVERSAMPLE = 16;

    // Clock cycles per oversample tick
    localparam int TICK_DIV = CLK_FREQ / (BAUD * OVERSAMPLE);
    localparam int TICK_DIV_W = $clog2(TICK_DIV);
    localparam int OS_CNT_W = $clog2(OVERSAMPLE);

    localparam int TX_FIFO_DEPTH = 4;
    localparam int RX_FIFO_DEPTH = 4;

    typedef logic [7:0] uart_byte_t;

    typedef struct packed {
        logic framing_err;
        uart_byte_t data;
    } rx_entry_t;

endpackage

`default_nettype wire

//--- common/axil_pkg.sv
`default_nettype none

package axil_pkg;

    localparam int ADDR_W = 4;
    localparam int DATA_W = 32;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    localparam logic [ADDR_W-1:0] REG_TXDATA = 4'h0;
    localparam logic [ADDR_W-1:0] REG_RXDATA = 4'h4;
    localparam logic [ADDR_W-1:0] REG_STATUS = 4'h8;
    localparam logic [ADDR_W-1:0] REG_CTRL = 4'hc;

    typedef struct packed {
        logic [ADDR_W-1:0] awaddr;
        logic awvalid;
        logic [DATA_W-1:0] wdata;
        logic wvalid;
        logic bready;
        logic [ADDR_W-1:0] araddr;
        logic arvalid;
        logic rready;
    } axil_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        resp_t bresp;
        logic bvalid;
        logic arready;
        logic [DATA_W-1:0] rdata;
        resp_t rresp;
        logic rvalid;
    } axil_rsp_t;

endpackage

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // First word falls through
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // Producers and consumers are expected to honour full and empty
    push_while_full: assert property (@(posedge clk) disable iff (rst) full |-> !push);
    pop_while_empty: assert property (@(posedge clk) disable iff (rst) empty |-> !pop);

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tick,
    input  logic                 en,
    input  logic                 valid,
    input  uart_pkg::uart_byte_t data,
    output logic                 ready,
    output logic                 tx
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t state;
    logic [uart_pkg::OS_CNT_W-1:0] os_cnt;
    logic [2:0] bit_idx;
    uart_pkg::uart_byte_t shift;
    logic bit_end;

    assign ready = (state == IDLE) && tick && en;
    // Last tick of a 16-tick bit
    assign bit_end = tick && (&os_cnt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            os_cnt <= '0;
            bit_idx <= '0;
            tx <= 1'b1;
        end else begin
            if (tick) begin
                os_cnt <= os_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (valid && ready) begin
                        state <= START;
                        os_cnt <= '0;
                        tx <= 1'b0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state <= DATA;
                        bit_idx <= '0;
                        tx <= shift[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                            tx <= 1'b1;
                        end else begin
                            tx <= shift[0];
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // LSB goes out first
    always_ff @(posedge clk) begin
        if (valid && ready) begin
            shift <= data;
        end else if (bit_end && (state == START || state == DATA)) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    line_idle_high: assert property (@(posedge clk) disable iff (rst) state == IDLE |-> tx);

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                tick,
    input  logic                en,
    input  logic                rx,
    output logic                valid,
    output uart_pkg::rx_entry_t entry
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    logic rx_d1;
    logic rx_d2;
    logic [1:0] flt_cnt;
    logic rx_bit;
    logic rx_prev;
    state_t state;
    logic [uart_pkg::OS_CNT_W-1:0] os_cnt;
    logic [2:0] bit_idx;
    uart_pkg::uart_byte_t shift;
    logic falling;
    logic mid_start;
    logic bit_end;

    assign falling = rx_prev && !rx_bit;
    assign mid_start = tick && (os_cnt == uart_pkg::OS_CNT_W'(uart_pkg::OVERSAMPLE / 2 - 1));
    // Once aligned to mid start bit, every 16th tick is a mid-bit sample
    assign bit_end = tick && (&os_cnt);

    // Synchronizer and hysteresis filter step once per tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_d1 <= 1'b1;
            rx_d2 <= 1'b1;
            flt_cnt <= 2'b11;
            rx_bit <= 1'b1;
            rx_prev <= 1'b1;
        end else if (tick) begin
            rx_d1 <= rx;
            rx_d2 <= rx_d1;
            if (rx_d2 && flt_cnt != 2'b11) begin
                flt_cnt <= flt_cnt + 1'b1;
            end else if (!rx_d2 && flt_cnt != 2'b00) begin
                flt_cnt <= flt_cnt - 1'b1;
            end
            if (flt_cnt == 2'b00) begin
                rx_bit <= 1'b0;
            end else if (flt_cnt == 2'b11) begin
                rx_bit <= 1'b1;
            end
            rx_prev <= rx_bit;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            os_cnt <= '0;
            bit_idx <= '0;
            valid <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (tick) begin
                os_cnt <= os_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (tick && en && falling) begin
                        state <= START;
                        os_cnt <= '0;
                    end
                end
                START: begin
                    // Glitch shorter than half a bit
                    if (mid_start) begin
                        state <= rx_bit ? IDLE : DATA;
                        os_cnt <= '0;
                        bit_idx <= '0;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= IDLE;
                        valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA && bit_end) begin
            shift <= {rx_bit, shift[7:1]};
        end
        if (state == STOP && bit_end) begin
            entry.data <= shift;
            entry.framing_err <= !rx_bit;
        end
    end

endmodule

`default_nettype wire

//--- uart/uart_core.sv
`timescale 1ns/1ps
`default_nettype none

module uart_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en,
    input  logic                 tx_valid,
    input  uart_pkg::uart_byte_t tx_data,
    output logic                 tx_ready,
    output logic                 rx_valid,
    output uart_pkg::rx_entry_t  rx_entry,
    input  logic                 rx,
    output logic                 tx
);

    logic [uart_pkg::TICK_DIV_W-1:0] div_cnt;
    logic tick;

    // Oversample tick shared by both directions
    assign tick = (div_cnt == uart_pkg::TICK_DIV_W'(uart_pkg::TICK_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    uart_tx i_tx (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .en    (en),
        .valid (tx_valid),
        .data  (tx_data),
        .ready (tx_ready),
        .tx    (tx)
    );

    uart_rx i_rx (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .en    (en),
        .rx    (rx),
        .valid (rx_valid),
        .entry (rx_entry)
    );

endmodule

`default_nettype wire

//--- hw/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  axil_pkg::axil_req_t  req,
    output axil_pkg::axil_rsp_t  rsp,
    output logic                 tx_push,
    output uart_pkg::uart_byte_t tx_push_data,
    input  logic                 tx_full,
    input  logic                 tx_empty,
    output logic                 rx_pop,
    input  uart_pkg::rx_entry_t  rx_pop_data,
    input  logic                 rx_full,
    input  logic                 rx_empty,
    input  logic                 rx_push,
    output logic                 en
);

    logic aw_ready_q;
    logic b_valid_q;
    axil_pkg::resp_t b_resp_q;
    logic ar_ready_q;
    logic r_valid_q;
    axil_pkg::resp_t r_resp_q;
    logic [axil_pkg::DATA_W-1:0] r_data_q;
    logic overrun_q;

    logic wr_hs;
    logic rd_hs;
    logic status_rd;
    axil_pkg::resp_t wr_resp;
    axil_pkg::resp_t rd_resp;
    logic [axil_pkg::DATA_W-1:0] rd_data;

    // Address and data phases are accepted together
    assign wr_hs = aw_ready_q && req.awvalid && req.wvalid;
    assign rd_hs = ar_ready_q && req.arvalid;

    assign tx_push = wr_hs && (req.awaddr == axil_pkg::REG_TXDATA) && !tx_full;
    assign tx_push_data = req.wdata[7:0];
    assign rx_pop = rd_hs && (req.araddr == axil_pkg::REG_RXDATA) && !rx_empty;
    assign status_rd = rd_hs && (req.araddr == axil_pkg::REG_STATUS);

    always_comb begin
        case (req.awaddr)
            axil_pkg::REG_TXDATA: wr_resp = tx_full ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
            axil_pkg::REG_CTRL:   wr_resp = axil_pkg::RESP_OKAY;
            default:              wr_resp = axil_pkg::RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_resp = axil_pkg::RESP_OKAY;
        case (req.araddr)
            axil_pkg::REG_RXDATA: begin
                if (rx_empty) begin
                    rd_resp = axil_pkg::RESP_SLVERR;
                end else begin
                    rd_data[8:0] = rx_pop_data;
                end
            end
            axil_pkg::REG_STATUS: rd_data[4:0] = {overrun_q, rx_full, rx_empty, tx_empty, tx_full};
            axil_pkg::REG_CTRL:   rd_data[0] = en;
            // TXDATA is write-only
            default:              rd_resp = axil_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_ready_q <= 1'b0;
            b_valid_q <= 1'b0;
            ar_ready_q <= 1'b0;
            r_valid_q <= 1'b0;
            en <= 1'b0;
            overrun_q <= 1'b0;
        end else begin
            aw_ready_q <= req.awvalid && req.wvalid && !aw_ready_q && !b_valid_q;
            ar_ready_q <= req.arvalid && !ar_ready_q && !r_valid_q;

            if (wr_hs) begin
                b_valid_q <= 1'b1;
            end else if (req.bready) begin
                b_valid_q <= 1'b0;
            end

            if (rd_hs) begin
                r_valid_q <= 1'b1;
            end else if (req.rready) begin
                r_valid_q <= 1'b0;
            end

            if (wr_hs && (req.awaddr == axil_pkg::REG_CTRL)) begin
                en <= req.wdata[0];
            end

            // A new drop wins over the clear from a STATUS read
            if (rx_push && rx_full) begin
                overrun_q <= 1'b1;
            end else if (status_rd) begin
                overrun_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            b_resp_q <= wr_resp;
        end
        if (rd_hs) begin
            r_resp_q <= rd_resp;
            r_data_q <= rd_data;
        end
    end

    always_comb begin
        rsp.awready = aw_ready_q;
        rsp.wready = aw_ready_q;
        rsp.bresp = b_resp_q;
        rsp.bvalid = b_valid_q;
        rsp.arready = ar_ready_q;
        rsp.rdata = r_data_q;
        rsp.rresp = r_resp_q;
        rsp.rvalid = r_valid_q;
    end

    bvalid_held: assert property (@(posedge clk) disable iff (rst)
        rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp));
    rvalid_held: assert property (@(posedge clk) disable iff (rst)
        rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rresp) && $stable(rsp.rdata));

endmodule

`default_nettype wire

//--- hw/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t req,
    output axil_pkg::axil_rsp_t rsp,
    input  logic                rx,
    output logic                tx
);

    uart_pkg::uart_byte_t tx_push_data;
    uart_pkg::uart_byte_t tx_pop_data;
    uart_pkg::rx_entry_t rx_entry;
    uart_pkg::rx_entry_t rx_pop_data;
    logic tx_push;
    logic tx_full;
    logic tx_empty;
    logic tx_valid;
    logic tx_ready;
    logic tx_pop;
    logic rx_valid;
    logic rx_push;
    logic rx_full;
    logic rx_empty;
    logic rx_pop;
    logic en;

    assign tx_valid = !tx_empty;
    assign tx_pop = tx_valid && tx_ready;
    // A full RX FIFO drops the entry
    assign rx_push = rx_valid && !rx_full;

    uart_regs i_regs (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .rsp          (rsp),
        .tx_push      (tx_push),
        .tx_push_data (tx_push_data),
        .tx_full      (tx_full),
        .tx_empty     (tx_empty),
        .rx_pop       (rx_pop),
        .rx_pop_data  (rx_pop_data),
        .rx_full      (rx_full),
        .rx_empty     (rx_empty),
        .rx_push      (rx_valid),
        .en           (en)
    );

    sync_fifo #(
        .payload_t (uart_pkg::uart_byte_t),
        .DEPTH     (uart_pkg::TX_FIFO_DEPTH)
    ) i_tx_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (tx_push),
        .push_data (tx_push_data),
        .full      (tx_full),
        .pop       (tx_pop),
        .pop_data  (tx_pop_data),
        .empty     (tx_empty)
    );

    sync_fifo #(
        .payload_t (uart_pkg::rx_entry_t),
        .DEPTH     (uart_pkg::RX_FIFO_DEPTH)
    ) i_rx_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (rx_push),
        .push_data (rx_entry),
        .full      (rx_full),
        .pop       (rx_pop),
        .pop_data  (rx_pop_data),
        .empty     (rx_empty)
    );

    uart_core i_core (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .tx_valid (tx_valid),
        .tx_data  (tx_pop_data),
        .tx_ready (tx_ready),
        .rx_valid (rx_valid),
        .rx_entry (rx_entry),
        .rx       (rx),
        .tx       (tx)
    );

endmodule

`default_nettype wire

//--- sim/tb_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top;

    localparam int NUM_ROWS = 8;
    localparam int BIT_CYCLES = uart_pkg::TICK_DIV * uart_pkg::OVERSAMPLE;
    // Burst and overrun phases add nine frames on top of the table rows
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 1000 + 12000;
    localparam int HS_LIMIT = 100;
    // Cycles allowed for each awaited frame
    localparam int RX_LIMIT = 2000;

    localparam logic [1:0] MODE_LOOP = 2'd0;
    localparam logic [1:0] MODE_BANG = 2'd1;
    localparam logic [1:0] MODE_EMPTY = 2'd2;

    typedef struct packed {
        logic [1:0] mode;
        uart_pkg::uart_byte_t data;
        logic framing_err;
        axil_pkg::resp_t resp;
        logic [4:0] status;
    } row_t;

    logic clk;
    logic rst;
    axil_pkg::axil_req_t req;
    axil_pkg::axil_rsp_t rsp;
    logic rx;
    logic tx;
    logic loopback;
    logic bang_line;
    logic en_written;
    row_t rows [NUM_ROWS];
    logic [31:0] lfsr;
    int rx_count = 0;
    int rx_target = 0;
    int value_errors = 0;
    int other_errors = 0;
    uart_pkg::uart_byte_t fillers [$];

    assign rx = loopback ? tx : bang_line;

    uart_top i_dut (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp),
        .rx  (rx),
        .tx  (tx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (i_dut.rx_valid) begin
            rx_count <= rx_count + 1;
        end
    end

    // Line idles high until the transmitter is enabled
    always @(negedge clk) begin
        if (!rst && !en_written && tx !== 1'b1) begin
            value_errors++;
            $display("CHECK FAILED at %0t: tx is %b while disabled", $time, tx);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    task automatic check_resp(input axil_pkg::resp_t got, input axil_pkg::resp_t exp,
                              input string what);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s response %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_entry(input uart_pkg::rx_entry_t got, input uart_pkg::rx_entry_t exp,
                               input string what);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got err=%b data=%h, expected err=%b data=%h",
                     $time, what, got.framing_err, got.data, exp.framing_err, exp.data);
        end
    endtask

    task automatic check_status(input logic [axil_pkg::DATA_W-1:0] got,
                                input logic [axil_pkg::DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic get_filler(output uart_pkg::uart_byte_t value);
        for (int i = 0; i < 8; i++) begin
            value[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Called and left 10 ns after a rising edge
    task automatic write_reg(input logic [axil_pkg::ADDR_W-1:0] addr,
                             input logic [axil_pkg::DATA_W-1:0] data,
                             output axil_pkg::resp_t resp);
        int cycles;
        cycles = 0;
        req.awaddr = addr;
        req.wdata = data;
        req.awvalid = 1'b1;
        req.wvalid = 1'b1;
        while (!(rsp.awready && rsp.wready) && cycles < HS_LIMIT) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (!(rsp.awready && rsp.wready)) begin
            other_errors++;
            $display("Write to offset %h was never accepted", addr);
        end
        @(posedge clk);
        #10;
        req.awvalid = 1'b0;
        req.wvalid = 1'b0;
        req.bready = 1'b1;
        cycles = 0;
        while (!rsp.bvalid && cycles < HS_LIMIT) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (!rsp.bvalid) begin
            other_errors++;
            $display("No write response for offset %h", addr);
        end
        resp = rsp.bresp;
        @(posedge clk);
        #10;
        req.bready = 1'b0;
    endtask

    task automatic read_reg(input logic [axil_pkg::ADDR_W-1:0] addr,
                            output logic [axil_pkg::DATA_W-1:0] data,
                            output axil_pkg::resp_t resp);
        int cycles;
        cycles = 0;
        req.araddr = addr;
        req.arvalid = 1'b1;
        while (!rsp.arready && cycles < HS_LIMIT) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (!rsp.arready) begin
            other_errors++;
            $display("Read from offset %h was never accepted", addr);
        end
        @(posedge clk);
        #10;
        req.arvalid = 1'b0;
        req.rready = 1'b1;
        cycles = 0;
        while (!rsp.rvalid && cycles < HS_LIMIT) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (!rsp.rvalid) begin
            other_errors++;
            $display("No read data for offset %h", addr);
        end
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        #10;
        req.rready = 1'b0;
    endtask

    task automatic write_check(input logic [axil_pkg::ADDR_W-1:0] addr,
                               input logic [axil_pkg::DATA_W-1:0] data,
                               input axil_pkg::resp_t exp_resp, input string what);
        axil_pkg::resp_t resp;
        write_reg(addr, data, resp);
        check_resp(resp, exp_resp, what);
    endtask

    task automatic read_check_rx(input uart_pkg::rx_entry_t exp,
                                 input axil_pkg::resp_t exp_resp, input string what);
        logic [axil_pkg::DATA_W-1:0] data;
        axil_pkg::resp_t resp;
        read_reg(axil_pkg::REG_RXDATA, data, resp);
        check_resp(resp, exp_resp, what);
        check_entry(data[8:0], exp, what);
    endtask

    task automatic read_check_status(input logic [4:0] exp, input string what);
        logic [axil_pkg::DATA_W-1:0] data;
        axil_pkg::resp_t resp;
        read_reg(axil_pkg::REG_STATUS, data, resp);
        check_resp(resp, axil_pkg::RESP_OKAY, what);
        check_status(data, {27'd0, exp}, what);
    endtask

    task automatic read_check_ctrl(input logic exp, input string what);
        logic [axil_pkg::DATA_W-1:0] data;
        axil_pkg::resp_t resp;
        read_reg(axil_pkg::REG_CTRL, data, resp);
        check_resp(resp, axil_pkg::RESP_OKAY, what);
        check_status(data, {31'd0, exp}, what);
    endtask

    task automatic wait_rx(input int target);
        int cycles;
        int limit;
        cycles = 0;
        limit = (target - rx_count) * RX_LIMIT;
        while (rx_count < target && cycles < limit) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (rx_count < target) begin
            other_errors++;
            $display("Timed out waiting for received byte number %0d", target);
        end
    endtask

    // Start bit, data LSB first, stop bit, then one idle bit
    task automatic send_frame(input uart_pkg::uart_byte_t value, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, value, 1'b0};
        loopback = 1'b0;
        for (int i = 0; i < 10; i++) begin
            bang_line = bits[i];
            repeat (BIT_CYCLES) @(posedge clk);
            #10;
        end
        bang_line = 1'b1;
        repeat (BIT_CYCLES) @(posedge clk);
        #10;
        loopback = 1'b1;
    endtask

    task automatic run_row(input row_t row);
        case (row.mode)
            MODE_LOOP: begin
                write_check(axil_pkg::REG_TXDATA, row.data, axil_pkg::RESP_OKAY, "TXDATA write");
                rx_target++;
                wait_rx(rx_target);
            end
            MODE_BANG: begin
                send_frame(row.data, !row.framing_err);
                rx_target++;
                wait_rx(rx_target);
            end
            default: begin
            end
        endcase
        read_check_rx({row.framing_err, row.data}, row.resp, "RXDATA table read");
        read_check_status(row.status, "STATUS after table row");
    endtask

    initial begin
        uart_pkg::uart_byte_t b;
        req = '0;
        rst = 1'b1;
        loopback = 1'b1;
        bang_line = 1'b1;
        en_written = 1'b0;
        lfsr = 32'h599c_0154;
        rows[0] = '{MODE_LOOP, 8'h55, 1'b0, axil_pkg::RESP_OKAY, 5'h06};
        rows[1] = '{MODE_LOOP, 8'ha3, 1'b0, axil_pkg::RESP_OKAY, 5'h06};
        rows[2] = '{MODE_BANG, 8'h3c, 1'b1, axil_pkg::RESP_OKAY, 5'h06};
        rows[3] = '{MODE_BANG, 8'hc5, 1'b0, axil_pkg::RESP_OKAY, 5'h06};
        rows[4] = '{MODE_EMPTY, 8'h00, 1'b0, axil_pkg::RESP_SLVERR, 5'h06};
        rows[5] = '{MODE_LOOP, 8'h01, 1'b0, axil_pkg::RESP_OKAY, 5'h06};
        rows[6] = '{MODE_LOOP, 8'hff, 1'b0, axil_pkg::RESP_OKAY, 5'h06};
        rows[7] = '{MODE_BANG, 8'h80, 1'b1, axil_pkg::RESP_OKAY, 5'h06};
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;

        read_check_status(5'h06, "STATUS after reset");
        read_check_ctrl(1'b0, "CTRL after reset");

        // Burst queues up while the transmitter is disabled
        for (int i = 0; i < 4; i++) begin
            write_check(axil_pkg::REG_TXDATA, rows[i].data, axil_pkg::RESP_OKAY, "TXDATA burst");
        end
        read_check_status(5'h05, "STATUS with TX FIFO full");
        get_filler(b);
        write_check(axil_pkg::REG_TXDATA, b, axil_pkg::RESP_SLVERR, "TXDATA write while full");
        en_written = 1'b1;
        write_check(axil_pkg::REG_CTRL, 32'd1, axil_pkg::RESP_OKAY, "CTRL enable");
        rx_target += 4;
        wait_rx(rx_target);
        for (int i = 0; i < 4; i++) begin
            read_check_rx({1'b0, rows[i].data}, axil_pkg::RESP_OKAY, "RXDATA burst read");
        end
        read_check_status(5'h06, "STATUS after burst");

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end

        // Fifth byte finds the RX FIFO full
        for (int i = 0; i < 5; i++) begin
            get_filler(b);
            fillers.push_back(b);
            write_check(axil_pkg::REG_TXDATA, b, axil_pkg::RESP_OKAY, "TXDATA overrun write");
        end
        rx_target += 5;
        wait_rx(rx_target);
        read_check_status(5'h1a, "STATUS after overrun");
        read_check_status(5'h0a, "STATUS after overrun clear");
        for (int i = 0; i < 4; i++) begin
            read_check_rx({1'b0, fillers[i]}, axil_pkg::RESP_OKAY, "RXDATA after overrun");
        end
        read_check_status(5'h06, "STATUS after drain");

        write_check(axil_pkg::REG_STATUS, 32'd0, axil_pkg::RESP_SLVERR, "STATUS write");
        write_check(axil_pkg::REG_RXDATA, 32'd0, axil_pkg::RESP_SLVERR, "RXDATA write");
        write_check(4'h2, 32'd0, axil_pkg::RESP_SLVERR, "unmapped write");
        read_check_rx('0, axil_pkg::RESP_SLVERR, "RXDATA read while empty");
        begin
            logic [axil_pkg::DATA_W-1:0] data;
            axil_pkg::resp_t resp;
            read_reg(4'h2, data, resp);
            check_resp(resp, axil_pkg::RESP_SLVERR, "unmapped read");
            read_reg(axil_pkg::REG_TXDATA, data, resp);
            check_resp(resp, axil_pkg::RESP_SLVERR, "TXDATA read");
        end

        read_check_ctrl(1'b1, "CTRL after enable");
        write_check(axil_pkg::REG_CTRL, 32'd0, axil_pkg::RESP_OKAY, "CTRL disable");
        en_written = 1'b0;
        read_check_ctrl(1'b0, "CTRL after disable");

        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/uart_pkg.sv
common/axil_pkg.sv
hw/sync_fifo.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_core.sv
hw/uart_regs.sv
hw/uart_top.sv
sim/tb_uart_top.sv

//--- Bender.yml
package:
  name: uart_axil

sources:
  - common/uart_pkg.sv
  - common/axil_pkg.sv
  - hw/sync_fifo.sv
  - uart/uart_tx.sv
  - uart/uart_rx.sv
  - uart/uart_core.sv
  - hw/uart_regs.sv
  - hw/uart_top.sv
  - target: simulation
    files:
      - sim/tb_uart_top.sv
